// ==== design/noc_pkg.sv ====
// network side of the bridge
// three 64-bit channels, each with its own valid/ready pair
package noc_pkg;

    // channel count and flit width
    localparam int NOC_CHANNELS = 3;
    localparam int NOC_FLIT_W = 64;

    // bits needed to name one channel
    localparam int NOC_CHAN_IDX_W = $clog2(NOC_CHANNELS);

    // one flit as seen by the network
    typedef logic [NOC_FLIT_W-1:0] noc_flit_t;

    // all channels side by side, index = channel number
    typedef noc_flit_t [NOC_CHANNELS-1:0] noc_bus_t;

    // one bit per channel
    // valid, ready and credit wires
    typedef logic [NOC_CHANNELS-1:0] chan_vec_t;

    // channel number, 0 to NOC_CHANNELS-1
    typedef logic [NOC_CHAN_IDX_W-1:0] chan_idx_t;

endpackage

// ==== design/bridge_pkg.sv ====
// link side of the bridge
// 32-bit words with a channel tag, credits flow back per channel
package bridge_pkg;

    import noc_pkg::*;

    // a flit crosses as two halves
    localparam int LINK_DATA_W = NOC_FLIT_W / 2;

    typedef logic [LINK_DATA_W-1:0] link_data_t;
    typedef logic [1:0] link_chan_t;

    // tag zero = nothing on the link
    // tag n+1 carries network channel n
    localparam link_chan_t LINK_IDLE = 2'd0;

    // one link word, the whole bus in each direction
    typedef struct packed {
        link_chan_t chan;
        link_data_t data;
    } link_word_t;

    // receive buffer depth per channel
    // also the sender's credit count after reset
    localparam int BRIDGE_CREDITS = 4;
    localparam int SEND_QUEUE_DEPTH = 2;

    typedef logic [2:0] credit_cnt_t;
    localparam credit_cnt_t CREDIT_INIT = credit_cnt_t'(BRIDGE_CREDITS);

    // serializer and deserializer states
    typedef enum logic {SEND_LOW, SEND_HIGH} send_state_e;
    typedef enum logic {RCV_LOW, RCV_HIGH} rcv_state_e;

    // network channel number to link tag
    function automatic link_chan_t chan_tag(int unsigned ch);
        return link_chan_t'(ch + 1);
    endfunction

endpackage

// ==== design/bridge_chan_fifo.sv ====
`timescale 1ns/1ps

// one-flit-wide synchronous queue
// send side holds SEND_QUEUE_DEPTH, receive side BRIDGE_CREDITS
module bridge_chan_fifo import noc_pkg::*, bridge_pkg::*; #(
    parameter int DEPTH = SEND_QUEUE_DEPTH
) (
    input  logic      fpga_clk,
    input  logic      rst,
    input  logic      push,
    input  noc_flit_t push_data,
    input  logic      pop,
    output noc_flit_t head,
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    noc_flit_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));

    // full blocks push even when a pop happens the same cycle
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // head read straight from the array
    // a push shows up here one cycle later
    assign head = mem[rd_ptr];

    always_ff @(posedge fpga_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge fpga_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy, unchanged on push and pop together
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/bridge_send.sv ====
`timescale 1ns/1ps

// send path, network to link
// per-channel queues, credit counters, round-robin pick,
// then each flit goes out as low half and high half
module bridge_send import noc_pkg::*, bridge_pkg::*; (
    input  logic       fpga_clk,
    input  logic       rst,
    input  noc_bus_t   network_out,
    input  chan_vec_t  data_out_val,
    output chan_vec_t  data_out_rdy,
    output link_word_t intcnct_out,
    input  chan_vec_t  intcnct_credit_out
);

    send_state_e state;

    // queue side
    noc_bus_t    q_head;
    chan_vec_t   q_push;
    chan_vec_t   q_pop;
    chan_vec_t   q_empty;
    chan_vec_t   q_full;

    // arbitration
    chan_vec_t   eligible;
    logic        grant_valid;
    chan_idx_t   grant_chan;
    chan_idx_t   last_chan;
    chan_idx_t   sel_chan;

    // one credit per flit the receiver can still hold
    credit_cnt_t credit_cnt [NOC_CHANNELS];

    // registered link word
    link_chan_t  link_chan_q;
    link_data_t  link_data_q;

    for (genvar i = 0; i < NOC_CHANNELS; i++) begin : g_chan
        bridge_chan_fifo #(
            .DEPTH(SEND_QUEUE_DEPTH)
        ) queue_i (
            .fpga_clk (fpga_clk),
            .rst      (rst),
            .push     (q_push[i]),
            .push_data(network_out[i]),
            .pop      (q_pop[i]),
            .head     (q_head[i]),
            .empty    (q_empty[i]),
            .full     (q_full[i])
        );

        assign data_out_rdy[i] = ~q_full[i];
        assign q_push[i] = data_out_val[i] & ~q_full[i];

        // flit leaves its queue while the high half is registered
        assign q_pop[i] = (state == SEND_HIGH) && (sel_chan == chan_idx_t'(i));

        // something to send and room on the far side
        assign eligible[i] = ~q_empty[i] && (credit_cnt[i] != '0);
    end

    // round robin, search starts one past the last winner
    always_comb begin
        int idx;
        idx = 0;
        grant_valid = 1'b0;
        grant_chan = '0;
        for (int k = 1; k <= NOC_CHANNELS; k++) begin
            idx = (int'(last_chan) + k) % NOC_CHANNELS;
            if (!grant_valid && eligible[idx]) begin
                grant_valid = 1'b1;
                grant_chan = chan_idx_t'(idx);
            end
        end
        // new pairs only start between pairs
        if (state != SEND_LOW) begin
            grant_valid = 1'b0;
        end
    end

    // serializer FSM and link tag
    always_ff @(posedge fpga_clk) begin
        if (rst) begin
            state <= SEND_LOW;
            link_chan_q <= LINK_IDLE;
            sel_chan <= '0;
            // so channel 0 wins first
            last_chan <= chan_idx_t'(NOC_CHANNELS - 1);
        end else begin
            case (state)
                SEND_LOW: begin
                    if (grant_valid) begin
                        link_chan_q <= chan_tag(grant_chan);
                        sel_chan <= grant_chan;
                        last_chan <= grant_chan;
                        state <= SEND_HIGH;
                    end else begin
                        link_chan_q <= LINK_IDLE;
                    end
                end
                // tag held for the second word
                SEND_HIGH: state <= SEND_LOW;
                default: state <= SEND_LOW;
            endcase
        end
    end

    // link data, low half on the grant, high half after
    // don't care while the tag is idle
    always_ff @(posedge fpga_clk) begin
        if (state == SEND_LOW) begin
            link_data_q <= q_head[grant_chan][LINK_DATA_W-1:0];
        end else begin
            link_data_q <= q_head[sel_chan][NOC_FLIT_W-1:LINK_DATA_W];
        end
    end

    assign intcnct_out = '{chan: link_chan_q, data: link_data_q};

    // credit counters
    // spent on the low half, returned pulse added the cycle after it arrives
    always_ff @(posedge fpga_clk) begin
        for (int i = 0; i < NOC_CHANNELS; i++) begin
            if (rst) begin
                credit_cnt[i] <= CREDIT_INIT;
            end else if (grant_valid && grant_chan == chan_idx_t'(i)) begin
                if (!intcnct_credit_out[i]) begin
                    credit_cnt[i] <= credit_cnt[i] - 1'b1;
                end
            end else if (intcnct_credit_out[i]) begin
                credit_cnt[i] <= credit_cnt[i] + 1'b1;
            end
        end
    end

endmodule

// ==== design/bridge_rcv.sv ====
`timescale 1ns/1ps

// receive path, link to network
// rebuilds flits from word pairs, buffers them per channel,
// returns one credit per flit handed to the network
module bridge_rcv import noc_pkg::*, bridge_pkg::*; (
    input  logic       fpga_clk,
    input  logic       rst,
    input  link_word_t intcnct_in,
    output chan_vec_t  intcnct_credit_in,
    output noc_bus_t   network_in,
    output chan_vec_t  data_in_val,
    input  chan_vec_t  data_in_rdy
);

    rcv_state_e state;

    // first word of the pair
    link_data_t low_half_q;
    link_chan_t tag_q;

    // completed flit, valid in RCV_HIGH
    noc_flit_t  flit_in;

    chan_vec_t  buf_push;
    chan_vec_t  buf_pop;
    chan_vec_t  buf_empty;
    chan_vec_t  credit_q;

    // high half arrives on the wire, low half from the register
    assign flit_in = {intcnct_in.data, low_half_q};

    // deserializer FSM
    always_ff @(posedge fpga_clk) begin
        if (rst) begin
            state <= RCV_LOW;
            tag_q <= LINK_IDLE;
        end else begin
            case (state)
                RCV_LOW: begin
                    // idle tag, nothing to do
                    if (intcnct_in.chan != LINK_IDLE) begin
                        tag_q <= intcnct_in.chan;
                        state <= RCV_HIGH;
                    end
                end
                // second word is pushed combinationally below
                RCV_HIGH: state <= RCV_LOW;
                default: state <= RCV_LOW;
            endcase
        end
    end

    // low half only matters once the tag is non-idle
    always_ff @(posedge fpga_clk) begin
        if (state == RCV_LOW) begin
            low_half_q <= intcnct_in.data;
        end
    end

    for (genvar i = 0; i < NOC_CHANNELS; i++) begin : g_chan
        // write on the cycle the high half is on the link
        assign buf_push[i] = (state == RCV_HIGH) && (tag_q == chan_tag(i));

        // never overflows while the sender respects credits
        bridge_chan_fifo #(
            .DEPTH(BRIDGE_CREDITS)
        ) buffer_i (
            .fpga_clk (fpga_clk),
            .rst      (rst),
            .push     (buf_push[i]),
            .push_data(flit_in),
            .pop      (buf_pop[i]),
            .head     (network_in[i]),
            .empty    (buf_empty[i]),
            .full     ()
        );

        assign data_in_val[i] = ~buf_empty[i];
        assign buf_pop[i] = data_in_val[i] & data_in_rdy[i];
    end

    // one-cycle credit pulse per flit leaving a buffer
    always_ff @(posedge fpga_clk) begin
        if (rst) begin
            credit_q <= '0;
        end else begin
            credit_q <= buf_pop;
        end
    end

    assign intcnct_credit_in = credit_q;

endmodule

// ==== design/fpga_bridge.sv ====
`timescale 1ns/1ps

// bridge top
// network channels out over the link through bridge_send,
// link back to network channels through bridge_rcv
module fpga_bridge import noc_pkg::*, bridge_pkg::*; (
    input  logic       fpga_clk,
    input  logic       rst,
    // network to link
    input  noc_bus_t   network_out,
    input  chan_vec_t  data_out_val,
    output chan_vec_t  data_out_rdy,
    // link to network
    output noc_bus_t   network_in,
    output chan_vec_t  data_in_val,
    input  chan_vec_t  data_in_rdy,
    // link, both directions
    output link_word_t intcnct_out,
    input  chan_vec_t  intcnct_credit_out,
    input  link_word_t intcnct_in,
    output chan_vec_t  intcnct_credit_in
);

    bridge_send send_i (
        .fpga_clk          (fpga_clk),
        .rst               (rst),
        .network_out       (network_out),
        .data_out_val      (data_out_val),
        .data_out_rdy      (data_out_rdy),
        .intcnct_out       (intcnct_out),
        .intcnct_credit_out(intcnct_credit_out)
    );

    bridge_rcv rcv_i (
        .fpga_clk         (fpga_clk),
        .rst              (rst),
        .intcnct_in       (intcnct_in),
        .intcnct_credit_in(intcnct_credit_in),
        .network_in       (network_in),
        .data_in_val      (data_in_val),
        .data_in_rdy      (data_in_rdy)
    );

endmodule

// ==== test/fpga_bridge_assertions.sv ====
`timescale 1ns/1ps

// link format and credit checks on the outbound link
module fpga_bridge_assertions import noc_pkg::*, bridge_pkg::*; (
    input logic        fpga_clk,
    input logic        rst,
    input link_word_t  intcnct_out,
    input credit_cnt_t credit_cnt [NOC_CHANNELS]
);

    // failures seen so far, read by the testbench at the end
    int unsigned fail_count = 0;

    // high when the current link word is the second of a pair
    logic in_pair;

    always_ff @(posedge fpga_clk) begin
        if (rst) begin
            in_pair <= 1'b0;
        end else if (in_pair) begin
            in_pair <= 1'b0;
        end else begin
            in_pair <= (intcnct_out.chan != LINK_IDLE);
        end
    end

    // low half always followed by a high half with the same tag
    pair_complete: assert property (@(posedge fpga_clk) disable iff (rst)
        (!in_pair && intcnct_out.chan != LINK_IDLE)
            |=> (intcnct_out.chan == $past(intcnct_out.chan)))
        else begin
            $error("link pair split, tag changed inside a pair");
            fail_count++;
        end

    for (genvar i = 0; i < NOC_CHANNELS; i++) begin : g_chan
        // counter already spent on this edge, so look one cycle back
        credit_held: assert property (@(posedge fpga_clk) disable iff (rst)
            (!in_pair && intcnct_out.chan == link_chan_t'(i + 1))
                |-> ($past(credit_cnt[i]) != '0))
            else begin
                $error("pair started on channel %0d without credit", i);
                fail_count++;
            end

        // never more credits than receive buffer slots
        credit_bound: assert property (@(posedge fpga_clk) disable iff (rst)
            int'(credit_cnt[i]) <= BRIDGE_CREDITS)
            else begin
                $error("credit counter %0d above buffer depth", i);
                fail_count++;
            end
    end

endmodule

bind fpga_bridge fpga_bridge_assertions assertions_i (
    .fpga_clk   (fpga_clk),
    .rst        (rst),
    .intcnct_out(intcnct_out),
    .credit_cnt (send_i.credit_cnt)
);

// ==== test/fpga_bridge_tb.sv ====
`timescale 1ns/1ps

// testbench for fpga_bridge with the link looped back onto itself
module fpga_bridge_tb import noc_pkg::*, bridge_pkg::*; ();

    // flits per channel in the random, back-pressure and full-load tests
    localparam int N_RAND = 20;
    localparam int N_HOLD = 8;
    localparam int N_SIDE = 10;
    localparam int N_LOAD = 16;
    localparam int TOTAL_FLITS = NOC_CHANNELS + NOC_CHANNELS * N_RAND + N_HOLD
                                 + 2 * N_SIDE + NOC_CHANNELS * N_LOAD;
    localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 8 + 1000;

    // both link words of one flit
    typedef struct packed {
        link_word_t high;
        link_word_t low;
    } link_pair_t;

    logic       fpga_clk;
    logic       rst;
    noc_bus_t   network_out;
    noc_bus_t   network_in;
    chan_vec_t  data_out_val;
    chan_vec_t  data_out_rdy;
    chan_vec_t  data_in_val;
    chan_vec_t  data_in_rdy;
    link_word_t intcnct_out;
    link_word_t intcnct_in;
    chan_vec_t  intcnct_credit_out;
    chan_vec_t  intcnct_credit_in;

    // expected flits per channel
    // one queue for the link and one for the network
    noc_flit_t   exp_flit [NOC_CHANNELS][$];
    link_pair_t  exp_link [NOC_CHANNELS][$];
    int unsigned pair_count [NOC_CHANNELS] = '{default: 0};
    int unsigned err_count = 0;
    int unsigned check_count = 0;
    int unsigned tests_run = 0;

    fpga_bridge dut_i (
        .fpga_clk          (fpga_clk),
        .rst               (rst),
        .network_out       (network_out),
        .data_out_val      (data_out_val),
        .data_out_rdy      (data_out_rdy),
        .network_in        (network_in),
        .data_in_val       (data_in_val),
        .data_in_rdy       (data_in_rdy),
        .intcnct_out       (intcnct_out),
        .intcnct_credit_out(intcnct_credit_out),
        .intcnct_in        (intcnct_in),
        .intcnct_credit_in (intcnct_credit_in)
    );

    // words and credits looped back
    assign intcnct_in = intcnct_out;
    assign intcnct_credit_out = intcnct_credit_in;

    initial begin
        fpga_clk = 1'b0;
        forever #20 fpga_clk = ~fpga_clk;
    end

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        check_count++;
        if (exp_v !== act_v) begin
            err_count++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic report_fail(input string what);
        err_count++;
        $display("%0t failure: %s", $time, what);
    endtask

    task automatic end_test(input string name, input int unsigned errs_before);
        tests_run++;
        $display("%0t test %s: %s", $time, name,
                 (err_count == errs_before) ? "pass" : "FAIL");
    endtask

    // tag is channel plus one and both words share it
    // low half goes first
    function automatic link_pair_t bridge_model(input int ch, input noc_flit_t flit);
        link_pair_t pair;
        pair.low.chan = link_chan_t'(ch + 1);
        pair.low.data = flit[LINK_DATA_W-1:0];
        pair.high.chan = link_chan_t'(ch + 1);
        pair.high.data = flit[NOC_FLIT_W-1:LINK_DATA_W];
        exp_flit[ch].push_back(flit);
        return pair;
    endfunction

    // valid and data held until ready is seen on a rising edge
    task automatic send_flit(input int ch, input noc_flit_t flit);
        @(negedge fpga_clk);
        network_out[ch] = flit;
        data_out_val[ch] = 1'b1;
        @(posedge fpga_clk);
        while (!data_out_rdy[ch]) begin
            @(posedge fpga_clk);
        end
        exp_link[ch].push_back(bridge_model(ch, flit));
    endtask

    task automatic send_stream(input int ch, input int n, input int unsigned max_gap);
        int unsigned gap;
        for (int i = 0; i < n; i++) begin
            send_flit(ch, {$urandom, $urandom});
            gap = $urandom_range(max_gap, 0);
            repeat (gap) begin
                @(negedge fpga_clk);
                data_out_val[ch] = 1'b0;
            end
        end
        @(negedge fpga_clk);
        data_out_val[ch] = 1'b0;
    endtask

    task automatic wait_chan_drained(input int ch);
        while (exp_flit[ch].size() != 0 || exp_link[ch].size() != 0) begin
            @(posedge fpga_clk);
        end
    endtask

    // extra cycles let the last credit pulses settle
    task automatic wait_all_drained();
        for (int ch = 0; ch < NOC_CHANNELS; ch++) begin
            wait_chan_drained(ch);
        end
        repeat (4) @(posedge fpga_clk);
    endtask

    function automatic int unsigned total_pairs();
        int unsigned sum;
        sum = 0;
        for (int ch = 0; ch < NOC_CHANNELS; ch++) begin
            sum += pair_count[ch];
        end
        return sum;
    endfunction

    // pairs up link words and compares them with the model
    initial begin : link_monitor
        link_word_t word;
        link_word_t low_word;
        link_pair_t exp_pair;
        logic       in_pair;
        int         ch;
        in_pair = 1'b0;
        low_word = '0;
        forever begin
            @(posedge fpga_clk);
            word = intcnct_out;
            if (rst) begin
                in_pair = 1'b0;
            end else if (!in_pair) begin
                if (word.chan != LINK_IDLE) begin
                    low_word = word;
                    in_pair = 1'b1;
                end
            end else begin
                in_pair = 1'b0;
                ch = int'(low_word.chan) - 1;
                pair_count[ch]++;
                if (exp_link[ch].size() == 0) begin
                    report_fail($sformatf("link pair on channel %0d, none expected", ch));
                end else begin
                    exp_pair = exp_link[ch].pop_front();
                    check_val("intcnct_out low", 64'(exp_pair.low), 64'(low_word));
                    check_val("intcnct_out high", 64'(exp_pair.high), 64'(word));
                end
            end
        end
    end

    // one network_in compare per valid and ready
    initial begin : network_monitor
        noc_flit_t exp_val;
        forever begin
            @(posedge fpga_clk);
            for (int ch = 0; ch < NOC_CHANNELS; ch++) begin
                if (!rst && data_in_val[ch] && data_in_rdy[ch]) begin
                    if (exp_flit[ch].size() == 0) begin
                        report_fail($sformatf("flit on network_in[%0d], none expected", ch));
                    end else begin
                        exp_val = exp_flit[ch].pop_front();
                        check_val($sformatf("network_in[%0d]", ch), exp_val, network_in[ch]);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge fpga_clk);
        $display("run did not finish within %0d cycles, flits stuck", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        int unsigned errs_before;
        int unsigned held_pairs;
        int unsigned load_start;
        void'($urandom(32'he516));
        rst = 1'b1;
        network_out = '0;
        data_out_val = '0;
        data_in_rdy = '1;
        repeat (4) @(posedge fpga_clk);
        @(negedge fpga_clk);
        rst = 1'b0;

        // state right after reset
        errs_before = err_count;
        @(posedge fpga_clk);
        check_val("data_in_val", '0, 64'(data_in_val));
        check_val("intcnct_out.chan", 64'(LINK_IDLE), 64'(intcnct_out.chan));
        check_val("intcnct_credit_in", '0, 64'(intcnct_credit_in));
        check_val("data_out_rdy", 64'(3'b111), 64'(data_out_rdy));
        end_test("reset", errs_before);

        // one flit per channel and one at a time
        errs_before = err_count;
        for (int ch = 0; ch < NOC_CHANNELS; ch++) begin
            send_flit(ch, {$urandom, $urandom});
            @(negedge fpga_clk);
            data_out_val[ch] = 1'b0;
            wait_all_drained();
        end
        end_test("single", errs_before);

        // all channels at once with random valid gaps
        errs_before = err_count;
        fork
            send_stream(0, N_RAND, 3);
            send_stream(1, N_RAND, 3);
            send_stream(2, N_RAND, 3);
        join
        wait_all_drained();
        end_test("random", errs_before);

        // channel 1 blocked so at most one buffer's worth may cross
        errs_before = err_count;
        held_pairs = pair_count[1];
        @(negedge fpga_clk);
        data_in_rdy[1] = 1'b0;
        fork
            send_stream(1, N_HOLD, 0);
            begin
                fork
                    send_stream(0, N_SIDE, 1);
                    send_stream(2, N_SIDE, 1);
                join
                wait_chan_drained(0);
                wait_chan_drained(2);
                repeat (20) @(posedge fpga_clk);
                held_pairs = pair_count[1] - held_pairs;
                if (int'(held_pairs) > BRIDGE_CREDITS) begin
                    report_fail($sformatf("%0d channel 1 pairs sent while blocked",
                                          held_pairs));
                end
                @(negedge fpga_clk);
                data_in_rdy[1] = 1'b1;
            end
        join
        wait_all_drained();
        end_test("backpressure", errs_before);

        // back-to-back valid on every channel
        errs_before = err_count;
        load_start = total_pairs();
        fork
            send_stream(0, N_LOAD, 0);
            send_stream(1, N_LOAD, 0);
            send_stream(2, N_LOAD, 0);
        join
        wait_all_drained();
        check_val("link pair count", 64'(NOC_CHANNELS * N_LOAD),
                  64'(total_pairs() - load_start));
        end_test("full_load", errs_before);

        if (dut_i.assertions_i.fail_count != 0) begin
            report_fail($sformatf("%0d assertion failures on the link",
                                  dut_i.assertions_i.fail_count));
        end
        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/noc_pkg.sv
design/bridge_pkg.sv
design/bridge_chan_fifo.sv
design/bridge_send.sv
design/bridge_rcv.sv
design/fpga_bridge.sv
test/fpga_bridge_assertions.sv
test/fpga_bridge_tb.sv

// ==== Makefile ====
SIM        = verilator
TOP        = fpga_bridge_tb
RTL_TOP    = fpga_bridge
FILELIST   = sources.f
FLAGS      = --binary --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
RUN_FLAGS  = +verilator+error+limit+1000
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
